// File: logic/map_entry.sv
// one architectural register of the map table
// speculative tag + ready bit, committed tag alongside
// resets to the identity mapping given by AREG_INDEX

`timescale 1ns/1ps
`default_nettype none
`include "rename_map_settings.svh"

module map_entry #(
    parameter int AREG_INDEX = 0    // reset tag
) (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire rename_map_pkg::entry_cmd_t cmd,
    input  wire rename_map_pkg::cdb_t       cdb,
    output rename_map_pkg::entry_state_t    state
);

    rename_map_pkg::entry_state_t state_nxt;
    logic                         cdb_hit;

    // broadcast compares against the current speculative tag only
    assign cdb_hit = cdb.valid & (cdb.pr == state.spec_pr);

    ////////////////////
    // next state
    ////////////////////

    always_comb begin
        state_nxt = state;

        // priority recover, then rename, then broadcast
        if (cmd.recover) begin
            state_nxt.spec_pr = state.arch_pr;  // pre-retire value
            state_nxt.ready   = 1'b1;
        end else if (cmd.spec_we) begin
            state_nxt.spec_pr = cmd.spec_pr;
            state_nxt.ready   = 1'b0;           // rename beats same-cycle cdb
        end else if (cdb_hit) begin
            state_nxt.ready   = 1'b1;
        end

        if (cmd.arch_we)
            state_nxt.arch_pr = cmd.arch_pr;    // retire write
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state.spec_pr <= rename_map_pkg::preg_t'(AREG_INDEX);
            state.ready   <= 1'b1;
            state.arch_pr <= rename_map_pkg::preg_t'(AREG_INDEX);
        end else begin
            state <= state_nxt;
        end
    end

endmodule

`default_nettype wire

// File: logic/map_lookup.sv
// source and old-tag lookup for one dispatch group
// combinational on registered table state
// older slots in the same group forward their new_pr, never ready
// no cdb forwarding here, broadcasts show up a cycle later

`timescale 1ns/1ps
`default_nettype none
`include "rename_map_settings.svh"

module map_lookup (
    input  wire rename_map_pkg::dispatch_slot_t [`RM_WIDTH-1:0] dispatch,
    input  wire rename_map_pkg::entry_state_t   [`RM_AREGS-1:0] state,
    output rename_map_pkg::lookup_t             [`RM_WIDTH-1:0] lookup
);

    logic [`RM_WIDTH-1:0] wr_dest;  // slot renames its dest

    always_comb begin
        for (int s = 0; s < `RM_WIDTH; s++)
            wr_dest[s] = dispatch[s].valid & dispatch[s].has_dest;
    end

    ////////////////////
    // table read
    ////////////////////

    always_comb begin
        for (int s = 0; s < `RM_WIDTH; s++) begin
            // start from the registered table
            lookup[s].src1_pr  = state[dispatch[s].src1_ar].spec_pr;
            lookup[s].src1_rdy = state[dispatch[s].src1_ar].ready;
            lookup[s].src2_pr  = state[dispatch[s].src2_ar].spec_pr;
            lookup[s].src2_rdy = state[dispatch[s].src2_ar].ready;
            lookup[s].old_pr   = state[dispatch[s].dest_ar].spec_pr;

            ////////////////////
            // in-group bypass
            ////////////////////

            // older slots are s+1 .. top, walk oldest first
            // so the youngest older writer is applied last
            for (int o = `RM_WIDTH - 1; o > s; o--) begin
                if (wr_dest[o]) begin
                    if (dispatch[o].dest_ar == dispatch[s].src1_ar) begin
                        lookup[s].src1_pr  = dispatch[o].new_pr;
                        lookup[s].src1_rdy = 1'b0;  // producer not done
                    end
                    if (dispatch[o].dest_ar == dispatch[s].src2_ar) begin
                        lookup[s].src2_pr  = dispatch[o].new_pr;
                        lookup[s].src2_rdy = 1'b0;
                    end
                    // old tag of a younger writer is the older new_pr
                    if (dispatch[o].dest_ar == dispatch[s].dest_ar)
                        lookup[s].old_pr = dispatch[o].new_pr;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/map_write_decode.sv
// per-entry write commands from one dispatch and one retire group
// purely combinational
// within a group the youngest slot wins (slot 0 over 1 over 2)
// recover kills dispatch writes but retire writes still go through

`timescale 1ns/1ps
`default_nettype none
`include "rename_map_settings.svh"

module map_write_decode (
    input  wire rename_map_pkg::dispatch_slot_t [`RM_WIDTH-1:0] dispatch,
    input  wire rename_map_pkg::retire_slot_t   [`RM_WIDTH-1:0] retire,
    input  wire logic                                          recover,
    output rename_map_pkg::entry_cmd_t          [`RM_AREGS-1:0] cmd
);

    logic [`RM_WIDTH-1:0] disp_we;  // slot actually renames
    logic [`RM_WIDTH-1:0] ret_we;   // slot actually commits

    ////////////////////
    // slot qualifiers
    ////////////////////

    always_comb begin
        for (int s = 0; s < `RM_WIDTH; s++) begin
            // no speculative writes while recovering
            disp_we[s] = dispatch[s].valid & dispatch[s].has_dest & ~recover;
            ret_we[s]  = retire[s].valid;
        end
    end

    ////////////////////
    // entry decode
    ////////////////////

    // scan oldest to youngest, later hit overwrites earlier one
    always_comb begin
        for (int i = 0; i < `RM_AREGS; i++) begin
            cmd[i]         = '0;
            cmd[i].recover = recover;   // every entry sees it

            // speculative half
            for (int s = `RM_WIDTH - 1; s >= 0; s--) begin
                if (disp_we[s] &&
                    dispatch[s].dest_ar == rename_map_pkg::areg_t'(i)) begin
                    cmd[i].spec_we = 1'b1;
                    cmd[i].spec_pr = dispatch[s].new_pr;
                end
            end

            // committed half, same ordering
            for (int s = `RM_WIDTH - 1; s >= 0; s--) begin
                if (ret_we[s] &&
                    retire[s].ar == rename_map_pkg::areg_t'(i)) begin
                    cmd[i].arch_we = 1'b1;
                    cmd[i].arch_pr = retire[s].pr;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/rename_map_pkg.sv
// shared types for the rename map
// field widths come from the settings header
// all structs packed, slot arrays are packed over RM_WIDTH

`default_nettype none
`include "rename_map_settings.svh"

package rename_map_pkg;

    ////////////////////
    // scalar types
    ////////////////////

    typedef logic [`RM_AREG_BITS-1:0] areg_t;   // arch register index
    typedef logic [`RM_PREG_BITS-1:0] preg_t;   // physical tag

    ////////////////////
    // port side
    ////////////////////

    // one instruction entering rename
    typedef struct packed {
        logic  valid;      // one cycle strobe
        logic  has_dest;   // writes a register
        areg_t dest_ar;
        preg_t new_pr;     // tag handed in from outside
        areg_t src1_ar;
        areg_t src2_ar;
    } dispatch_slot_t;

    // rename result per slot
    typedef struct packed {
        preg_t src1_pr;
        logic  src1_rdy;
        preg_t src2_pr;
        logic  src2_rdy;
        preg_t old_pr;     // previous mapping of dest
    } lookup_t;

    typedef struct packed {
        logic  valid;
        areg_t ar;         // retiring dest
        preg_t pr;         // its committed tag
    } retire_slot_t;

    // completion broadcast, single lane
    typedef struct packed {
        logic  valid;
        preg_t pr;
    } cdb_t;

    ////////////////////
    // inside the table
    ////////////////////

    typedef struct packed {
        logic  spec_we;    // dispatch rename hits this entry
        preg_t spec_pr;
        logic  arch_we;    // retire hits this entry
        preg_t arch_pr;
        logic  recover;    // copy committed into speculative
    } entry_cmd_t;

    typedef struct packed {
        preg_t spec_pr;
        logic  ready;
        preg_t arch_pr;
    } entry_state_t;

endpackage

`default_nettype wire

// File: logic/rename_map_settings.svh
// sizing for the rename map slice
// 32 architectural registers, one physical tag per entry
// tag width bounds the physical register file at 64
// dispatch and retire share one width, slot 0 is the youngest

`ifndef RENAME_MAP_SETTINGS_SVH
`define RENAME_MAP_SETTINGS_SVH

////////////////////
// register space
////////////////////

`define RM_AREGS        32  // architectural registers
`define RM_AREG_BITS    5   // arch index width

////////////////////
// physical tags
////////////////////

`define RM_PREG_BITS    6   // physical tag width

// instructions per group, dispatch and retire alike
`define RM_WIDTH        3

`endif

// File: logic/rename_map_top.sv
// register rename map, speculative + architectural tables
// new tags come in on dispatch, no free list here
// lookups are same-cycle, table updates land on the next edge
// no back-pressure, caller stalls dispatch

`timescale 1ns/1ps
`default_nettype none
`include "rename_map_settings.svh"

module rename_map_top (
    input  wire logic                                          clk,
    input  wire logic                                          rst,
    input  wire rename_map_pkg::dispatch_slot_t [`RM_WIDTH-1:0] dispatch,
    input  wire rename_map_pkg::retire_slot_t   [`RM_WIDTH-1:0] retire,
    input  wire rename_map_pkg::cdb_t                          cdb,
    input  wire logic                                          recover,
    output rename_map_pkg::lookup_t             [`RM_WIDTH-1:0] lookup
);

    rename_map_pkg::entry_cmd_t   [`RM_AREGS-1:0] cmd;     // decoder -> entries
    rename_map_pkg::entry_state_t [`RM_AREGS-1:0] state;   // entries -> lookup

    ////////////////////
    // write side
    ////////////////////

    map_write_decode i_map_write_decode (
        .dispatch (dispatch),
        .retire   (retire),
        .recover  (recover),
        .cmd      (cmd)
    );

    // one entry per arch register, reset to identity
    for (genvar i = 0; i < `RM_AREGS; i++) begin : g_entry
        map_entry #(
            .AREG_INDEX (i)
        ) i_map_entry (
            .clk   (clk),
            .rst   (rst),
            .cmd   (cmd[i]),
            .cdb   (cdb),       // each entry does its own tag compare
            .state (state[i])
        );
    end

    ////////////////////
    // read side
    ////////////////////

    map_lookup i_map_lookup (
        .dispatch (dispatch),
        .state    (state),
        .lookup   (lookup)
    );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the rename map testbench with Verilator
# exit status is nonzero unless the log holds the pass line

cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -f tb.f \
    --top-module rename_map_tb -Mdir obj_dir -o rename_map_sim > build.log 2>&1 \
    && ./obj_dir/rename_map_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or run failed"; exit 1; }

cat sim.log
grep -q "PASS: all tests" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: tb.f
+incdir+logic
logic/rename_map_pkg.sv
logic/map_write_decode.sv
logic/map_entry.sv
logic/map_lookup.sv
logic/rename_map_top.sv
verif/rename_map_checker.sv
verif/rename_map_scoreboard.sv
verif/rename_map_tb.sv

// File: verif/rename_map_checker.sv
// assertions bound into rename_map_top
// sampled on the falling edge, inputs and table are settled there
// bypass check skips recover cycles, lookups are undefined then

`timescale 1ns/1ps
`default_nettype none
`include "rename_map_settings.svh"

module rename_map_checker (
    input  wire logic                                           clk,
    input  wire logic                                           rst,
    input  wire rename_map_pkg::dispatch_slot_t [`RM_WIDTH-1:0] dispatch,
    input  wire logic                                           recover,
    input  wire rename_map_pkg::lookup_t        [`RM_WIDTH-1:0] lookup,
    input  wire rename_map_pkg::entry_state_t   [`RM_AREGS-1:0] state
);

    logic [`RM_WIDTH-1:0] src1_fwd;     // src1 hits an older dest in the group
    logic [`RM_WIDTH-1:0] src2_fwd;
    logic [`RM_AREGS-1:0] ready_bits;   // one per table entry

    always_comb begin
        for (int i = 0; i < `RM_AREGS; i++)
            ready_bits[i] = state[i].ready;
        for (int s = 0; s < `RM_WIDTH; s++) begin
            src1_fwd[s] = 1'b0;
            src2_fwd[s] = 1'b0;
            for (int o = s + 1; o < `RM_WIDTH; o++) begin   // older slots only
                if (dispatch[o].valid && dispatch[o].has_dest) begin
                    src1_fwd[s] |= dispatch[o].dest_ar == dispatch[s].src1_ar;
                    src2_fwd[s] |= dispatch[o].dest_ar == dispatch[s].src2_ar;
                end
            end
        end
    end

    ////////////////////
    // per slot
    ////////////////////

    for (genvar s = 0; s < `RM_WIDTH; s++) begin : g_slot
        a_known: assert property (@(negedge clk) disable iff (rst)
            dispatch[s].valid |-> !$isunknown(lookup[s]))
            else $error("slot %0d lookup has unknown bits", s);

        // producer is in the same group, cannot be done yet
        a_fwd_busy: assert property (@(negedge clk) disable iff (rst)
            dispatch[s].valid && !recover |->
                (!src1_fwd[s] || !lookup[s].src1_rdy) &&
                (!src2_fwd[s] || !lookup[s].src2_rdy))
            else $error("slot %0d source from older slot reads ready", s);
    end

    // table comes back fully ready after a flush
    a_recover_ready: assert property (@(negedge clk) disable iff (rst)
        recover |=> &ready_bits)
        else $error("ready bits not all set one cycle after recover");

endmodule

`default_nettype wire

// File: verif/rename_map_scoreboard.sv
// reference model and compare for the rename map
// samples on the falling edge, model steps after each compare
// lookups are compared for valid slots only, never in a recover cycle

`timescale 1ns/1ps
`default_nettype none
`include "rename_map_settings.svh"

module rename_map_scoreboard (
    input  wire logic                                           clk,
    input  wire logic                                           rst,
    input  wire rename_map_pkg::dispatch_slot_t [`RM_WIDTH-1:0] dispatch,
    input  wire rename_map_pkg::retire_slot_t   [`RM_WIDTH-1:0] retire,
    input  wire rename_map_pkg::cdb_t                           cdb,
    input  wire logic                                           recover,
    input  wire rename_map_pkg::lookup_t        [`RM_WIDTH-1:0] lookup,
    input  wire logic [7:0]                                     test_num,
    input  wire logic                                           test_done,
    input  wire logic                                           all_done,
    output int                                                  error_count,
    output int                                                  tests_reported,
    output logic                                                summary_done
);

    typedef rename_map_pkg::lookup_t [`RM_WIDTH-1:0] lookup_grp_t;

    rename_map_pkg::preg_t ref_spec [`RM_AREGS];    // speculative table
    logic                  ref_rdy  [`RM_AREGS];
    rename_map_pkg::preg_t ref_arch [`RM_AREGS];    // committed table
    int total_checks;
    int test_checks;
    int test_errors;

    function automatic string test_name(input int n);
        case (n)
            1: return "reset_identity";
            2: return "rename_chain";
            3: return "group_bypass";
            4: return "cdb_wakeup";
            5: return "retire_recover";
            6: return "random_mix";
            default: return "idle";
        endcase
    endfunction

    // youngest slot older than s that renames ar, -1 if none
    function automatic int older_writer(
        input rename_map_pkg::dispatch_slot_t [`RM_WIDTH-1:0] d,
        input int s,
        input rename_map_pkg::areg_t ar
    );
        for (int o = s + 1; o < `RM_WIDTH; o++) begin
            if (d[o].valid && d[o].has_dest && d[o].dest_ar == ar)
                return o;
        end
        return -1;
    endfunction

    ////////////////////
    // reference lookup
    ////////////////////

    function automatic lookup_grp_t expected_lookup(
        input rename_map_pkg::dispatch_slot_t [`RM_WIDTH-1:0] d
    );
        lookup_grp_t res;
        int w;
        for (int s = 0; s < `RM_WIDTH; s++) begin
            res[s].src1_pr  = ref_spec[d[s].src1_ar];
            res[s].src1_rdy = ref_rdy[d[s].src1_ar];
            res[s].src2_pr  = ref_spec[d[s].src2_ar];
            res[s].src2_rdy = ref_rdy[d[s].src2_ar];
            res[s].old_pr   = ref_spec[d[s].dest_ar];
            w = older_writer(d, s, d[s].src1_ar);
            if (w >= 0) begin
                res[s].src1_pr  = d[w].new_pr;   // in flight, not ready
                res[s].src1_rdy = 1'b0;
            end
            w = older_writer(d, s, d[s].src2_ar);
            if (w >= 0) begin
                res[s].src2_pr  = d[w].new_pr;
                res[s].src2_rdy = 1'b0;
            end
            w = older_writer(d, s, d[s].dest_ar);
            if (w >= 0)
                res[s].old_pr = d[w].new_pr;
        end
        return res;
    endfunction

    task automatic compare_group();
        lookup_grp_t exp_l;
        exp_l = expected_lookup(dispatch);
        for (int s = 0; s < `RM_WIDTH; s++) begin
            if (dispatch[s].valid) begin
                test_checks++;
                total_checks++;
                if (lookup[s] !== exp_l[s]) begin
                    error_count++;
                    test_errors++;
                    $display("MISMATCH %s slot %0d: expected %05h actual %05h",
                             test_name(int'(test_num)), s, exp_l[s], lookup[s]);
                end
            end
        end
    endtask

    ////////////////////
    // model update
    ////////////////////

    task automatic update_model();
        if (recover) begin
            for (int i = 0; i < `RM_AREGS; i++) begin
                ref_spec[i] = ref_arch[i];   // committed value before this retire
                ref_rdy[i]  = 1'b1;
            end
        end else begin
            for (int i = 0; i < `RM_AREGS; i++) begin
                if (cdb.valid && ref_spec[i] == cdb.pr)
                    ref_rdy[i] = 1'b1;       // wakeup on current tag
            end
            for (int s = `RM_WIDTH - 1; s >= 0; s--) begin   // oldest first, youngest lands last
                if (dispatch[s].valid && dispatch[s].has_dest) begin
                    ref_spec[dispatch[s].dest_ar] = dispatch[s].new_pr;
                    ref_rdy[dispatch[s].dest_ar]  = 1'b0;
                end
            end
        end
        for (int s = `RM_WIDTH - 1; s >= 0; s--) begin
            if (retire[s].valid)
                ref_arch[retire[s].ar] = retire[s].pr;
        end
    endtask

    always @(negedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RM_AREGS; i++) begin
                ref_spec[i] = rename_map_pkg::preg_t'(i);   // identity map
                ref_rdy[i]  = 1'b1;
                ref_arch[i] = rename_map_pkg::preg_t'(i);
            end
            error_count    = 0;
            tests_reported = 0;
            summary_done   = 1'b0;
            total_checks   = 0;
            test_checks    = 0;
            test_errors    = 0;
        end else begin
            if (!recover)
                compare_group();
            update_model();
            if (test_done) begin
                $display("test %0d %s: %0d checks, %0d errors", test_num,
                         test_name(int'(test_num)), test_checks, test_errors);
                tests_reported++;
                test_checks = 0;
                test_errors = 0;
            end
            if (all_done && !summary_done) begin
                $display("summary: %0d tests, %0d checks, %0d errors",
                         tests_reported, total_checks, error_count);
                summary_done = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: verif/rename_map_tb.sv
// testbench top for the rename map
// five directed tests then a seeded random mix
// inputs change on the rising edge and the scoreboard does every compare

`timescale 1ns/1ps
`default_nettype none
`include "rename_map_settings.svh"

module rename_map_tb;

    localparam int WAIT_LIMIT = 20;     // cycles per scoreboard wait

    logic clk;
    logic rst;
    logic recover;
    rename_map_pkg::dispatch_slot_t [`RM_WIDTH-1:0] dispatch;
    rename_map_pkg::retire_slot_t   [`RM_WIDTH-1:0] retire;
    rename_map_pkg::cdb_t                           cdb;
    rename_map_pkg::lookup_t        [`RM_WIDTH-1:0] lookup;

    logic [7:0] test_num;
    logic       test_done;
    logic       all_done;
    logic       summary_done;
    logic       timed_out;
    int         error_count;
    int         tests_reported;
    int         waited;

    rename_map_top i_rename_map_top (
        .clk      (clk),
        .rst      (rst),
        .dispatch (dispatch),
        .retire   (retire),
        .cdb      (cdb),
        .recover  (recover),
        .lookup   (lookup)
    );

    rename_map_scoreboard i_rename_map_scoreboard (
        .clk            (clk),
        .rst            (rst),
        .dispatch       (dispatch),
        .retire         (retire),
        .cdb            (cdb),
        .recover        (recover),
        .lookup         (lookup),
        .test_num       (test_num),
        .test_done      (test_done),
        .all_done       (all_done),
        .error_count    (error_count),
        .tests_reported (tests_reported),
        .summary_done   (summary_done)
    );

    bind rename_map_top rename_map_checker i_rename_map_checker (
        .clk      (clk),
        .rst      (rst),
        .dispatch (dispatch),
        .recover  (recover),
        .lookup   (lookup),
        .state    (state)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;      // 8 ns period
    end

    ////////////////////
    // drive helpers
    ////////////////////

    task clear_inputs();
        dispatch <= '0;
        retire   <= '0;
        cdb      <= '0;
        recover  <= 1'b0;
    endtask

    task next_cycle();
        @(posedge clk);
        clear_inputs();             // later drives in the same step win
    endtask

    task set_slot(input int s, input logic has_dest, input int dest, input int new_pr,
                  input int src1, input int src2);
        dispatch[s] <= '{valid: 1'b1, has_dest: has_dest,
                         dest_ar: rename_map_pkg::areg_t'(dest),
                         new_pr: rename_map_pkg::preg_t'(new_pr),
                         src1_ar: rename_map_pkg::areg_t'(src1),
                         src2_ar: rename_map_pkg::areg_t'(src2)};
    endtask

    task retire_slot(input int s, input int ar, input int pr);
        retire[s] <= '{valid: 1'b1, ar: rename_map_pkg::areg_t'(ar),
                       pr: rename_map_pkg::preg_t'(pr)};
    endtask

    task send_cdb(input int pr);
        cdb <= '{valid: 1'b1, pr: rename_map_pkg::preg_t'(pr)};
    endtask

    ////////////////////
    // directed tests
    ////////////////////

    task reset_identity();
        for (int k = 0; k < 11; k++) begin
            next_cycle();
            for (int s = 0; s < `RM_WIDTH; s++)     // reads only over all regs
                set_slot(s, 1'b0, 3 * k + s, 0, 3 * k + s + 1, 31 - 3 * k - s);
        end
    endtask

    task rename_chain();
        next_cycle();
        set_slot(2, 1'b1, 5, 40, 1, 2);     // r5 -> 40
        next_cycle();
        set_slot(0, 1'b1, 5, 41, 5, 5);     // old tag 40 and busy sources
        next_cycle();
        set_slot(1, 1'b0, 0, 0, 5, 6);
    endtask

    task group_bypass();
        next_cycle();
        set_slot(2, 1'b1, 7, 42, 7, 8);     // three writers of r7 in one group
        set_slot(1, 1'b1, 7, 43, 7, 9);
        set_slot(0, 1'b1, 7, 44, 7, 7);
        next_cycle();
        set_slot(0, 1'b0, 0, 0, 7, 8);      // youngest tag 44 stays
    endtask

    task cdb_wakeup();
        next_cycle();
        send_cdb(44);                       // r7 producer done
        set_slot(1, 1'b0, 0, 0, 7, 3);      // still busy in the broadcast cycle
        next_cycle();
        set_slot(0, 1'b0, 0, 0, 7, 7);
        send_cdb(50);                       // no entry holds 50
        next_cycle();
        set_slot(0, 1'b0, 0, 0, 5, 7);
        next_cycle();
        set_slot(2, 1'b1, 5, 45, 5, 3);     // rename r5 while 41 broadcasts
        send_cdb(41);
        next_cycle();
        set_slot(1, 1'b0, 0, 0, 5, 5);
    endtask

    task retire_recover();
        next_cycle();
        retire_slot(2, 3, 46);
        retire_slot(0, 3, 47);              // youngest wins r3
        retire_slot(1, 4, 48);
        next_cycle();
        set_slot(2, 1'b1, 3, 49, 3, 4);
        next_cycle();
        set_slot(0, 1'b0, 0, 0, 3, 4);
        next_cycle();
        recover <= 1'b1;
        retire_slot(0, 6, 51);              // lands after the copy
        set_slot(0, 1'b1, 6, 52, 6, 6);     // dropped by recover
        next_cycle();
        set_slot(2, 1'b0, 0, 0, 3, 4);
        set_slot(1, 1'b0, 0, 0, 7, 5);
        set_slot(0, 1'b0, 6, 0, 6, 6);
        next_cycle();
        recover <= 1'b1;
        next_cycle();
        set_slot(0, 1'b0, 0, 0, 6, 3);      // r6 now 51
    endtask

    task random_mix(input int cycles);
        for (int c = 0; c < cycles; c++) begin
            next_cycle();
            for (int s = 0; s < `RM_WIDTH; s++) begin
                if ($urandom_range(3) != 0)
                    set_slot(s, 1'($urandom_range(1)), $urandom_range(31),
                             $urandom_range(63), $urandom_range(31), $urandom_range(31));
                if ($urandom_range(2) == 0)
                    retire_slot(s, $urandom_range(31), $urandom_range(63));
            end
            if ($urandom_range(1) == 1)
                send_cdb($urandom_range(63));
            if ($urandom_range(24) == 0)
                recover <= 1'b1;            // rare flush
        end
    endtask

    // strobe done then wait for the scoreboard to log the test
    task finish_test(input int n);
        next_cycle();
        test_done <= 1'b1;
        next_cycle();
        test_done <= 1'b0;
        waited = 0;
        while (tests_reported < n && waited < WAIT_LIMIT) begin
            next_cycle();
            waited++;
        end
        if (tests_reported < n) begin
            $display("timeout: scoreboard never reported test %0d", n);
            timed_out = 1'b1;
        end
    endtask

    initial begin
        void'($urandom(32'he02b_13d8));
        rst       = 1'b1;
        recover   = 1'b0;
        dispatch  = '0;
        retire    = '0;
        cdb       = '0;
        test_num  = 8'd0;
        test_done = 1'b0;
        all_done  = 1'b0;
        timed_out = 1'b0;
        for (int k = 0; k < 4; k++)
            @(posedge clk);
        rst <= 1'b0;
        for (int n = 1; n <= 6; n++) begin
            if (!timed_out) begin
                test_num <= 8'(n);
                case (n)
                    1: reset_identity();
                    2: rename_chain();
                    3: group_bypass();
                    4: cdb_wakeup();
                    5: retire_recover();
                    default: random_mix(300);
                endcase
                finish_test(n);
            end
        end
        all_done <= 1'b1;
        waited = 0;
        while (!summary_done && waited < WAIT_LIMIT) begin
            next_cycle();
            waited++;
        end
        if (!summary_done) begin
            $display("timeout: scoreboard never printed its summary");
            timed_out = 1'b1;
        end
        if (!timed_out && error_count == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire
